// ==== flist.f ====
design/ex_types_pkg.sv
design/rv_ops_pkg.sv
design/alu.sv
design/branch_unit.sv
design/mult_stage.sv
design/mult_pipeline.sv
design/completion_queue.sv
design/ex_unit.sv
sim/ex_unit_checker.sv
sim/ex_unit_tb.sv

// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f flist.f --top-module ex_unit_tb -o ex_unit_sim
	./obj_dir/ex_unit_sim > sim.log 2>&1; status=$$?; cat sim.log; exit $$status
	@if grep -q "TEST FAILED" sim.log; then echo "simulation reported a failure"; exit 1; fi

clean:
	rm -rf obj_dir sim.log

// ==== sim/ex_unit_tb.sv ====
// default parameters only; stimulus from a seeded LCG, the checker module does all comparing
`timescale 1ns/1ps

module ex_unit_tb;

	localparam int NUM_TESTS   = 6;
	localparam int TEST_ISSUES = 84 + 350 + 40 + 48 + 120 + 30; // issues per test, in order
	localparam int CLOCK_NS    = 40;
	localparam int WATCHDOG_NS = (TEST_ISSUES + 10 * NUM_TESTS) * 2 * CLOCK_NS;

	logic                      clock, reset, issue_valid, branch_uncond, test_done;
	logic                      complete_valid, take_branch;
	ex_types_pkg::exec_unit_t  issue_unit;
	rv_ops_pkg::alu_func_t     alu_func;
	rv_ops_pkg::br_func_t      br_func;
	rv_ops_pkg::opa_sel_t      opa_select;
	rv_ops_pkg::opb_sel_t      opb_select;
	ex_types_pkg::word_t       rs1_value, rs2_value, pc, imm, complete_result, branch_target;
	ex_types_pkg::tag_t        dest_tag, complete_tag;
	int                        test_id, passed_tests, failed_tests;

	ex_types_pkg::word_t  lcg_state = 32'd3980;
	ex_types_pkg::word_t  corner [5] = '{32'h0, 32'd31, 32'h7fff_ffff, 32'h8000_0000, 32'hffff_ffff};
	rv_ops_pkg::br_func_t br_codes [6] = '{rv_ops_pkg::br_beq, rv_ops_pkg::br_bne,
		rv_ops_pkg::br_blt, rv_ops_pkg::br_bge, rv_ops_pkg::br_bltu, rv_ops_pkg::br_bgeu};

	ex_unit i_ex_unit (.*);

	ex_unit_checker i_checker (.*);

	always #(CLOCK_NS / 2) clock = ~clock;

	function automatic ex_types_pkg::word_t next_rand();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	// upper bits, the low LCG bits repeat too quickly
	function automatic int unsigned rand_below(input int unsigned n);
		return (next_rand() >> 16) % n;
	endfunction

	function automatic ex_types_pkg::tag_t rand_tag();
		return ex_types_pkg::tag_t'(1 + rand_below(63)); // never zero
	endfunction

	////////////////////////////////////////////////////////////
	// drive tasks, all on the falling edge
	////////////////////////////////////////////////////////////

	task automatic issue_op(input ex_types_pkg::exec_unit_t unit, input rv_ops_pkg::alu_func_t af,
		input rv_ops_pkg::br_func_t bf, input logic unc, input rv_ops_pkg::opa_sel_t sa,
		input rv_ops_pkg::opb_sel_t sb, input ex_types_pkg::word_t r1,
		input ex_types_pkg::word_t r2, input ex_types_pkg::tag_t tag);
		@(negedge clock);
		issue_valid   = 1'b1;
		issue_unit    = unit;
		alu_func      = af;
		br_func       = bf;
		branch_uncond = unc;
		opa_select    = sa;
		opb_select    = sb;
		rs1_value     = r1;
		rs2_value     = r2;
		pc            = next_rand() & 32'hffff_fffc; // word aligned
		imm           = next_rand();
		dest_tag      = tag;
	endtask

	task automatic issue_random(input ex_types_pkg::tag_t tag);
		issue_op(ex_types_pkg::exec_unit_t'(rand_below(3)), rv_ops_pkg::alu_func_t'(rand_below(14)),
			br_codes[rand_below(6)], rand_below(2) == 1, rv_ops_pkg::opa_sel_t'(rand_below(3)),
			rv_ops_pkg::opb_sel_t'(rand_below(2)), next_rand(), next_rand(), tag);
	endtask

	// idle so the queue drains, then one cycle of test_done
	task automatic finish_test();
		repeat (10) begin
			@(negedge clock);
			issue_valid = 1'b0;
		end
		@(negedge clock);
		test_done = 1'b1;
		@(negedge clock);
		test_done = 1'b0;
		test_id++;
	endtask

	initial begin
		ex_types_pkg::word_t r1;
		clock = 1'b0;
		reset = 1'b1;
		issue_valid = 1'b0;
		issue_unit = ex_types_pkg::unit_alu;
		alu_func = rv_ops_pkg::alu_add;
		br_func = rv_ops_pkg::br_beq;
		branch_uncond = 1'b0;
		opa_select = rv_ops_pkg::opa_rs1;
		opb_select = rv_ops_pkg::opb_rs2;
		rs1_value = '0;
		rs2_value = '0;
		pc = '0;
		imm = '0;
		dest_tag = '0;
		test_done = 1'b0;
		test_id = 1;
		repeat (3) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;

		// 1: every alu function with every operand select
		for (int f = 0; f < 14; f++)
			for (int sa = 0; sa < 3; sa++)
				for (int sb = 0; sb < 2; sb++)
					issue_op(ex_types_pkg::unit_alu, rv_ops_pkg::alu_func_t'(f), rv_ops_pkg::br_beq,
						1'b0, rv_ops_pkg::opa_sel_t'(sa), rv_ops_pkg::opb_sel_t'(sb),
						next_rand(), next_rand(), rand_tag());
		finish_test();

		// 2: corner operands, shifts of 0 and 31 come from the low bits
		for (int f = 0; f < 14; f++)
			for (int i = 0; i < 5; i++)
				for (int j = 0; j < 5; j++)
					issue_op(ex_types_pkg::unit_alu, rv_ops_pkg::alu_func_t'(f), rv_ops_pkg::br_beq,
						1'b0, rv_ops_pkg::opa_rs1, rv_ops_pkg::opb_rs2, corner[i], corner[j],
						rand_tag());
		finish_test();

		// 3: one multiply per cycle
		repeat (40)
			issue_op(ex_types_pkg::unit_mult, rv_ops_pkg::alu_add, rv_ops_pkg::br_beq, 1'b0,
				rv_ops_pkg::opa_rs1, rv_ops_pkg::opb_rs2, next_rand(), next_rand(), rand_tag());
		finish_test();

		// 4: branches, half of them with equal operands
		for (int f = 0; f < 6; f++)
			for (int u = 0; u < 2; u++)
				for (int k = 0; k < 4; k++) begin
					r1 = next_rand();
					issue_op(ex_types_pkg::unit_branch, rv_ops_pkg::alu_add, br_codes[f], u == 1,
						rv_ops_pkg::opa_sel_t'(k % 2), rv_ops_pkg::opb_imm, r1,
						(k < 2) ? r1 : next_rand(), rand_tag());
				end
		finish_test();

		repeat (120) issue_random(rand_tag()); // 5: mixed traffic
		finish_test();

		repeat (30) issue_random((rand_below(2) == 0) ? ex_types_pkg::tag_t'(0) : rand_tag());
		finish_test(); // 6: tag zero

		$display("tests passed %0d, tests failed %0d", passed_tests, failed_tests);
		if (failed_tests == 0 && passed_tests == NUM_TESTS) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
		$display("TEST FAILED");
		$finish;
	end

endmodule

// ==== sim/ex_unit_checker.sv ====
// samples at the rising edge, so DUT inputs must change on the falling edge only
`timescale 1ns/1ps

module ex_unit_checker #(
	parameter int MULT_STAGES = ex_types_pkg::DEFAULT_MULT_STAGES,
	parameter int QUEUE_DEPTH = ex_types_pkg::DEFAULT_QUEUE_DEPTH
) (
	input  logic                     clock, reset, issue_valid, branch_uncond, test_done,
	input  ex_types_pkg::exec_unit_t issue_unit,
	input  rv_ops_pkg::alu_func_t    alu_func,
	input  rv_ops_pkg::br_func_t     br_func,
	input  rv_ops_pkg::opa_sel_t     opa_select,
	input  rv_ops_pkg::opb_sel_t     opb_select,
	input  ex_types_pkg::word_t      rs1_value, rs2_value, pc, imm,
	input  ex_types_pkg::tag_t       dest_tag,
	input  logic                     complete_valid, take_branch,
	input  ex_types_pkg::tag_t       complete_tag,
	input  ex_types_pkg::word_t      complete_result, branch_target,
	input  int                       test_id,
	output int                       passed_tests, failed_tests
);

	localparam int SH = rv_ops_pkg::SHAMT_BITS;

	ex_types_pkg::tag_t  model_tag [$]; // writes in queue order
	ex_types_pkg::word_t model_result [$];
	logic                pipe_valid [MULT_STAGES]; // multiplies still in flight
	ex_types_pkg::tag_t  pipe_tag [MULT_STAGES];
	ex_types_pkg::word_t pipe_result [MULT_STAGES];
	logic                br_pending, br_take;
	ex_types_pkg::word_t br_target;
	int                  checks, errors;

	////////////////////////////////////////////////////////////
	// reference model
	////////////////////////////////////////////////////////////

	function automatic ex_types_pkg::word_t expected_result(input ex_types_pkg::exec_unit_t unit,
		input rv_ops_pkg::alu_func_t func, input ex_types_pkg::word_t a, input ex_types_pkg::word_t b,
		input ex_types_pkg::word_t rs1, input ex_types_pkg::word_t rs2, input ex_types_pkg::word_t pc);
		longint          ps;
		longint unsigned pu;
		if (unit == ex_types_pkg::unit_mult)
			return rs1 * rs2; // low word of rs1 times rs2
		if (unit == ex_types_pkg::unit_branch)
			return pc + 32'd4; // link
		case (func)
			rv_ops_pkg::alu_add:  return a + b;
			rv_ops_pkg::alu_sub:  return a - b;
			rv_ops_pkg::alu_slt:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			rv_ops_pkg::alu_sltu: return (a < b) ? 32'd1 : 32'd0;
			rv_ops_pkg::alu_and:  return a & b;
			rv_ops_pkg::alu_or:   return a | b;
			rv_ops_pkg::alu_xor:  return a ^ b;
			rv_ops_pkg::alu_sll:  return a << b[SH-1:0];
			rv_ops_pkg::alu_srl:  return a >> b[SH-1:0];
			rv_ops_pkg::alu_sra:  return ex_types_pkg::word_t'($signed(a) >>> b[SH-1:0]);
			rv_ops_pkg::alu_mul:  return a * b;
			rv_ops_pkg::alu_mulh: begin
				ps = longint'($signed(a)) * longint'($signed(b));
				return ex_types_pkg::word_t'(ps >>> 32);
			end
			rv_ops_pkg::alu_mulhsu: begin
				ps = longint'($signed(a)) * longint'({32'b0, b}); // fits, |a*b| < 2^63
				return ex_types_pkg::word_t'(ps >>> 32);
			end
			rv_ops_pkg::alu_mulhu: begin
				pu = {32'b0, a} * {32'b0, b};
				return ex_types_pkg::word_t'(pu >> 32);
			end
			default: return '0;
		endcase
	endfunction

	function automatic logic branch_taken(input rv_ops_pkg::br_func_t func, input logic uncond,
		input ex_types_pkg::word_t rs1, input ex_types_pkg::word_t rs2);
		logic cond;
		case (func)
			rv_ops_pkg::br_beq:  cond = (rs1 == rs2);
			rv_ops_pkg::br_bne:  cond = (rs1 != rs2);
			rv_ops_pkg::br_blt:  cond = ($signed(rs1) < $signed(rs2));
			rv_ops_pkg::br_bge:  cond = !($signed(rs1) < $signed(rs2));
			rv_ops_pkg::br_bltu: cond = (rs1 < rs2);
			rv_ops_pkg::br_bgeu: cond = !(rs1 < rs2);
			default:             cond = 1'b0;
		endcase
		return uncond || cond;
	endfunction

	////////////////////////////////////////////////////////////
	// compare at every rising edge
	////////////////////////////////////////////////////////////

	always @(posedge clock) begin
		ex_types_pkg::word_t a, b, exp_result, mult_result_out;
		ex_types_pkg::tag_t  exp_tag, mult_tag_out;
		logic                mult_valid_out;
		if (reset) begin
			model_tag.delete();
			model_result.delete();
			for (int i = 0; i < MULT_STAGES; i++)
				pipe_valid[i] = 1'b0;
			br_pending = 1'b0;
			checks = 0;
			errors = 0;
			passed_tests = 0;
			failed_tests = 0;
		end else begin
			// retire first, it shows the state before this edge
			if (complete_valid) begin
				checks++;
				if (model_tag.size() == 0) begin
					$display("error at %0t: completion of tag %0d with nothing outstanding",
						$time, complete_tag);
					errors++;
				end else begin
					exp_tag = model_tag.pop_front();
					exp_result = model_result.pop_front();
					if (complete_tag !== exp_tag || complete_result !== exp_result) begin
						$display("error at %0t: completed tag %0d result %h, expected tag %0d result %h",
							$time, complete_tag, complete_result, exp_tag, exp_result);
						errors++;
					end
				end
			end

			if (br_pending)
				checks++;
			if (take_branch !== (br_pending && br_take)) begin
				$display("error at %0t: take_branch %b, expected %b", $time, take_branch,
					br_pending && br_take);
				errors++;
			end else if (br_pending && branch_target !== br_target) begin
				$display("error at %0t: branch_target %h, expected %h", $time, branch_target,
					br_target);
				errors++;
			end

			mult_valid_out = pipe_valid[MULT_STAGES-1]; // issued MULT_STAGES edges ago
			mult_tag_out = pipe_tag[MULT_STAGES-1];
			mult_result_out = pipe_result[MULT_STAGES-1];
			for (int i = MULT_STAGES - 1; i > 0; i--) begin
				pipe_valid[i] = pipe_valid[i-1];
				pipe_tag[i] = pipe_tag[i-1];
				pipe_result[i] = pipe_result[i-1];
			end

			case (opa_select)
				rv_ops_pkg::opa_rs1: a = rs1_value;
				rv_ops_pkg::opa_pc:  a = pc;
				default:             a = '0;
			endcase
			b = (opb_select == rv_ops_pkg::opb_imm) ? imm : rs2_value;
			exp_result = expected_result(issue_unit, alu_func, a, b, rs1_value, rs2_value, pc);

			pipe_valid[0] = issue_valid && (issue_unit == ex_types_pkg::unit_mult);
			pipe_tag[0] = dest_tag;
			pipe_result[0] = exp_result;

			if (mult_valid_out && mult_tag_out != '0) begin // mult entry goes in first
				model_tag.push_back(mult_tag_out);
				model_result.push_back(mult_result_out);
			end
			if (issue_valid && issue_unit != ex_types_pkg::unit_mult && dest_tag != '0) begin
				model_tag.push_back(dest_tag);
				model_result.push_back(exp_result);
			end
			if (model_tag.size() > QUEUE_DEPTH) begin
				$display("error at %0t: %0d results outstanding, more than queue depth %0d",
					$time, model_tag.size(), QUEUE_DEPTH);
				errors++;
			end

			br_pending = issue_valid && (issue_unit == ex_types_pkg::unit_branch);
			br_take = branch_taken(br_func, branch_uncond, rs1_value, rs2_value);
			br_target = a + b;

			if (test_done) begin
				if (model_tag.size() != 0) begin
					$display("test %0d ended with %0d results that never completed", test_id,
						model_tag.size());
					errors++;
				end
				if (checks == 0) begin
					$display("test %0d made no comparisons at all", test_id);
					errors++;
				end
				$display("test %0d %s: %0d checks, %0d errors", test_id,
					(errors == 0) ? "ok" : "failed", checks, errors);
				if (errors == 0)
					passed_tests++;
				else
					failed_tests++;
				checks = 0;
				errors = 0;
			end
		end
	end

endmodule

// ==== design/ex_unit.sv ====
// single-issue execute stage; no back-pressure, QUEUE_DEPTH must cover MULT_STAGES + 2
`timescale 1ns/1ps

module ex_unit #(
	parameter int MULT_STAGES = ex_types_pkg::DEFAULT_MULT_STAGES,
	parameter int QUEUE_DEPTH = ex_types_pkg::DEFAULT_QUEUE_DEPTH
) (
	input  logic                   clock,
	input  logic                   reset,
	input  logic                   issue_valid,
	input  ex_types_pkg::exec_unit_t issue_unit,
	input  rv_ops_pkg::alu_func_t  alu_func,
	input  rv_ops_pkg::br_func_t   br_func,
	input  logic                   branch_uncond,
	input  rv_ops_pkg::opa_sel_t   opa_select,
	input  rv_ops_pkg::opb_sel_t   opb_select,
	input  ex_types_pkg::word_t    rs1_value,
	input  ex_types_pkg::word_t    rs2_value,
	input  ex_types_pkg::word_t    pc,
	input  ex_types_pkg::word_t    imm,
	input  ex_types_pkg::tag_t     dest_tag,
	output logic                   complete_valid,
	output ex_types_pkg::tag_t     complete_tag,
	output ex_types_pkg::word_t    complete_result,
	output logic                   take_branch,
	output ex_types_pkg::word_t    branch_target
);

	logic                alu_start, mult_start, br_start;
	ex_types_pkg::word_t opa, opb;
	ex_types_pkg::word_t alu_result, br_link, mult_product, exec_result;
	ex_types_pkg::tag_t  mult_tag;
	logic                mult_done, mult_push, exec_push;

	////////////////////////////////////////////////////////////
	// issue decode and operand select
	////////////////////////////////////////////////////////////

	assign alu_start  = issue_valid && (issue_unit == ex_types_pkg::unit_alu);
	assign mult_start = issue_valid && (issue_unit == ex_types_pkg::unit_mult);
	assign br_start   = issue_valid && (issue_unit == ex_types_pkg::unit_branch);

	always_comb begin
		case (opa_select)
			rv_ops_pkg::opa_rs1: opa = rs1_value;
			rv_ops_pkg::opa_pc:  opa = pc;
			default:             opa = '0; // opa_zero, e.g. lui
		endcase
		opb = (opb_select == rv_ops_pkg::opb_imm) ? imm : rs2_value;
	end

	////////////////////////////////////////////////////////////
	// units
	////////////////////////////////////////////////////////////

	alu i_alu (.opa(opa), .opb(opb), .func(alu_func), .result(alu_result));

	branch_unit i_branch_unit (
		.clock(clock), .reset(reset), .start(br_start), .uncond(branch_uncond),
		.func(br_func), .rs1(rs1_value), .rs2(rs2_value), .opa(opa), .opb(opb),
		.pc(pc), .link(br_link), .take_branch(take_branch), .branch_target(branch_target)
	);

	mult_pipeline #(.MULT_STAGES(MULT_STAGES)) i_mult_pipeline (
		.clock(clock), .reset(reset), .start(mult_start),
		.mcand(rs1_value), .mplier(rs2_value), .tag_in(dest_tag),
		.product(mult_product), .tag_out(mult_tag), .done(mult_done)
	);

	// alu and branch share the second write slot, tag 0 never enters the queue
	assign exec_result = br_start ? br_link : alu_result;
	assign exec_push   = (alu_start || br_start) && (dest_tag != '0);
	assign mult_push   = mult_done && (mult_tag != '0);

	completion_queue #(.QUEUE_DEPTH(QUEUE_DEPTH)) i_completion_queue (
		.clock(clock), .reset(reset),
		.mult_push(mult_push), .mult_tag(mult_tag), .mult_result(mult_product),
		.exec_push(exec_push), .exec_tag(dest_tag), .exec_result(exec_result),
		.complete_valid(complete_valid), .complete_tag(complete_tag),
		.complete_result(complete_result)
	);

	issue_unit_legal: assert property (@(posedge clock) disable iff (reset)
		issue_valid |-> (alu_start || mult_start || br_start))
		else $error("issue with undefined unit select %0d", issue_unit);

endmodule

// ==== design/completion_queue.sv ====
// in-order completion buffer, two writes and one retire per cycle, no full signal
`timescale 1ns/1ps

module completion_queue #(
	parameter int QUEUE_DEPTH = ex_types_pkg::DEFAULT_QUEUE_DEPTH
) (
	input  logic                clock,
	input  logic                reset,
	input  logic                mult_push,
	input  ex_types_pkg::tag_t  mult_tag,
	input  ex_types_pkg::word_t mult_result,
	input  logic                exec_push,
	input  ex_types_pkg::tag_t  exec_tag,
	input  ex_types_pkg::word_t exec_result,
	output logic                complete_valid,
	output ex_types_pkg::tag_t  complete_tag,
	output ex_types_pkg::word_t complete_result
);

	localparam int IDX_BITS = $clog2(QUEUE_DEPTH);
	localparam int CNT_BITS = $clog2(QUEUE_DEPTH + 1);

	ex_types_pkg::tag_t  tag_mem    [QUEUE_DEPTH];
	ex_types_pkg::word_t result_mem [QUEUE_DEPTH];

	logic [IDX_BITS-1:0] head, tail, tail_plus1, exec_idx;
	logic [CNT_BITS-1:0] count;
	logic [1:0]          n_push;
	logic                pop;

	// wraps for depths that are not a power of two
	function automatic logic [IDX_BITS-1:0] next_idx(input logic [IDX_BITS-1:0] idx);
		return (idx == IDX_BITS'(QUEUE_DEPTH - 1)) ? '0 : idx + 1'b1;
	endfunction

	assign tail_plus1 = next_idx(tail);
	assign exec_idx   = mult_push ? tail_plus1 : tail; // mult entry goes first
	assign n_push     = {1'b0, mult_push} + {1'b0, exec_push};
	assign pop        = (count != '0);

	assign complete_valid  = pop;
	assign complete_tag    = tag_mem[head];
	assign complete_result = result_mem[head];

	////////////////////////////////////////////////////////////
	// storage
	////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (mult_push) begin
			tag_mem[tail]    <= mult_tag;
			result_mem[tail] <= mult_result;
		end
		if (exec_push) begin
			tag_mem[exec_idx]    <= exec_tag;
			result_mem[exec_idx] <= exec_result;
		end
	end

	////////////////////////////////////////////////////////////
	// pointers
	////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			head  <= '0;
			tail  <= '0;
			count <= '0;
		end else begin
			if (pop)
				head <= next_idx(head); // head retires every non-empty cycle
			case (n_push)
				2'd1:    tail <= tail_plus1;
				2'd2:    tail <= next_idx(tail_plus1);
				default: tail <= tail;
			endcase
			count <= count + CNT_BITS'(n_push) - CNT_BITS'(pop);
		end
	end

	no_overflow: assert property (@(posedge clock) disable iff (reset)
		(int'(count) + int'(n_push) - int'(pop)) <= QUEUE_DEPTH)
		else $error("completion queue overflow, count %0d", count);

	no_null_tag: assert property (@(posedge clock) disable iff (reset)
		(mult_push |-> mult_tag != '0) and (exec_push |-> exec_tag != '0))
		else $error("push with destination tag zero");

endmodule

// ==== design/mult_pipeline.sv ====
// pipelined multiplier, low word only, one new operation accepted every cycle
`timescale 1ns/1ps

module mult_pipeline #(
	parameter int MULT_STAGES = ex_types_pkg::DEFAULT_MULT_STAGES
) (
	input  logic                clock,
	input  logic                reset,
	input  logic                start,
	input  ex_types_pkg::word_t mcand,
	input  ex_types_pkg::word_t mplier,
	input  ex_types_pkg::tag_t  tag_in,
	output ex_types_pkg::word_t product,
	output ex_types_pkg::tag_t  tag_out,
	output logic                done
);

	// element i feeds slice i, the last element is the pipeline output
	ex_types_pkg::word_t prod_chain   [0:MULT_STAGES];
	ex_types_pkg::word_t mplier_chain [0:MULT_STAGES];
	ex_types_pkg::word_t mcand_chain  [0:MULT_STAGES];
	ex_types_pkg::tag_t  tag_chain    [0:MULT_STAGES];
	logic                start_chain  [0:MULT_STAGES];

	assign prod_chain[0]   = '0; // nothing accumulated yet
	assign mplier_chain[0] = mplier;
	assign mcand_chain[0]  = mcand;
	assign tag_chain[0]    = tag_in;
	assign start_chain[0]  = start;

	for (genvar i = 0; i < MULT_STAGES; i++) begin : g_slice
		mult_stage #(.MULT_STAGES(MULT_STAGES)) i_mult_stage (
			.clock(clock), .reset(reset), .start(start_chain[i]),
			.product_in(prod_chain[i]), .mplier_in(mplier_chain[i]),
			.mcand_in(mcand_chain[i]), .tag_in(tag_chain[i]),
			.done(start_chain[i+1]), .tag_out(tag_chain[i+1]),
			.product_out(prod_chain[i+1]), .mplier_out(mplier_chain[i+1]),
			.mcand_out(mcand_chain[i+1])
		);
	end

	assign product = prod_chain[MULT_STAGES];
	assign tag_out = tag_chain[MULT_STAGES];
	assign done    = start_chain[MULT_STAGES];

endmodule

// ==== design/mult_stage.sv ====
// one multiplier slice of XLEN/MULT_STAGES bits; MULT_STAGES must divide XLEN
`timescale 1ns/1ps

module mult_stage #(
	parameter int MULT_STAGES = ex_types_pkg::DEFAULT_MULT_STAGES
) (
	input  logic                clock,
	input  logic                reset,
	input  logic                start,
	input  ex_types_pkg::word_t product_in,
	input  ex_types_pkg::word_t mplier_in,
	input  ex_types_pkg::word_t mcand_in,
	input  ex_types_pkg::tag_t  tag_in,
	output logic                done,
	output ex_types_pkg::tag_t  tag_out,
	output ex_types_pkg::word_t product_out,
	output ex_types_pkg::word_t mplier_out,
	output ex_types_pkg::word_t mcand_out
);

	localparam int SLICE_BITS = ex_types_pkg::XLEN / MULT_STAGES;

	ex_types_pkg::word_t prod_in_reg, partial_reg, partial_product;

	assign partial_product = mplier_in[SLICE_BITS-1:0] * mcand_in; // truncated to a word
	assign product_out     = prod_in_reg + partial_reg;

	always_ff @(posedge clock) begin
		prod_in_reg <= product_in;
		partial_reg <= partial_product;
		mplier_out  <= mplier_in >> SLICE_BITS; // next slice sees its bits at the bottom
		mcand_out   <= mcand_in << SLICE_BITS;  // weighted for the next slice
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			done    <= 1'b0;
			tag_out <= '0;
		end else begin
			done    <= start;
			tag_out <= tag_in;
		end
	end

	slice_width_exact: assert property (@(posedge clock)
		(SLICE_BITS * MULT_STAGES) == ex_types_pkg::XLEN)
		else $error("MULT_STAGES %0d does not divide XLEN", MULT_STAGES);

endmodule

// ==== design/branch_unit.sv ====
// branch resolve; take and target are registered and hold for one cycle only
`timescale 1ns/1ps

module branch_unit (
	input  logic                 clock,
	input  logic                 reset,
	input  logic                 start,
	input  logic                 uncond,
	input  rv_ops_pkg::br_func_t func,
	input  ex_types_pkg::word_t  rs1,
	input  ex_types_pkg::word_t  rs2,
	input  ex_types_pkg::word_t  opa,
	input  ex_types_pkg::word_t  opb,
	input  ex_types_pkg::word_t  pc,
	output ex_types_pkg::word_t  link,
	output logic                 take_branch,
	output ex_types_pkg::word_t  branch_target
);

	logic cond, take;

	always_comb begin
		case (func)
			rv_ops_pkg::br_beq:  cond = (rs1 == rs2);
			rv_ops_pkg::br_bne:  cond = (rs1 != rs2);
			rv_ops_pkg::br_blt:  cond = ($signed(rs1) < $signed(rs2));
			rv_ops_pkg::br_bge:  cond = ($signed(rs1) >= $signed(rs2));
			rv_ops_pkg::br_bltu: cond = (rs1 < rs2);
			rv_ops_pkg::br_bgeu: cond = (rs1 >= rs2);
			default:             cond = 1'b0; // reserved funct3 never taken
		endcase
	end

	assign take = uncond || cond; // jal/jalr ignore the compare
	assign link = pc + 32'd4;     // return address for jal/jalr

	always_ff @(posedge clock) begin
		if (reset) begin
			take_branch <= 1'b0;
		end else begin
			take_branch <= start && take; // single-cycle strobe
		end
	end

	// target only meaningful alongside take_branch
	always_ff @(posedge clock) begin
		if (start) begin
			branch_target <= opa + opb;
		end
	end

endmodule

// ==== design/alu.sv ====
// combinational integer alu; undefined func codes give zero
`timescale 1ns/1ps

module alu (
	input  ex_types_pkg::word_t   opa,
	input  ex_types_pkg::word_t   opb,
	input  rv_ops_pkg::alu_func_t func,
	output ex_types_pkg::word_t   result
);

	localparam int XLEN = ex_types_pkg::XLEN;

	logic [2*XLEN-1:0]            ss_mul, su_mul, uu_mul; // full width products
	logic [rv_ops_pkg::SHAMT_BITS-1:0] shamt;

	// extend to double width first, then a plain unsigned multiply is exact mod 2^64
	assign ss_mul = {{XLEN{opa[XLEN-1]}}, opa} * {{XLEN{opb[XLEN-1]}}, opb};
	assign su_mul = {{XLEN{opa[XLEN-1]}}, opa} * {{XLEN{1'b0}}, opb};
	assign uu_mul = {{XLEN{1'b0}}, opa} * {{XLEN{1'b0}}, opb};
	assign shamt  = opb[rv_ops_pkg::SHAMT_BITS-1:0];

	always_comb begin
		case (func)
			rv_ops_pkg::alu_add:    result = opa + opb;
			rv_ops_pkg::alu_sub:    result = opa - opb;
			rv_ops_pkg::alu_slt:    result = ex_types_pkg::word_t'($signed(opa) < $signed(opb));
			rv_ops_pkg::alu_sltu:   result = ex_types_pkg::word_t'(opa < opb);
			rv_ops_pkg::alu_and:    result = opa & opb;
			rv_ops_pkg::alu_or:     result = opa | opb;
			rv_ops_pkg::alu_xor:    result = opa ^ opb;
			rv_ops_pkg::alu_sll:    result = opa << shamt;
			rv_ops_pkg::alu_srl:    result = opa >> shamt;
			rv_ops_pkg::alu_sra:    result = $signed(opa) >>> shamt; // fills with sign bit
			rv_ops_pkg::alu_mul:    result = uu_mul[XLEN-1:0];   // low word same for all signs
			rv_ops_pkg::alu_mulh:   result = ss_mul[2*XLEN-1:XLEN];
			rv_ops_pkg::alu_mulhsu: result = su_mul[2*XLEN-1:XLEN];
			rv_ops_pkg::alu_mulhu:  result = uu_mul[2*XLEN-1:XLEN];
			default:                result = '0;
		endcase
	end

endmodule

// ==== design/rv_ops_pkg.sv ====
// operation encodings; branch codes follow the RV32 funct3 field, other codes are local
package rv_ops_pkg;

	localparam int SHAMT_BITS = 5; // shifts use opb[4:0]

	// fourteen alu functions, mulh variants included
	typedef enum logic [3:0] {
		alu_add,
		alu_sub,
		alu_slt,
		alu_sltu,
		alu_and,
		alu_or,
		alu_xor,
		alu_sll,
		alu_srl,
		alu_sra,
		alu_mul,
		alu_mulh,
		alu_mulhsu,
		alu_mulhu
	} alu_func_t;

	// funct3 of the branch opcode
	typedef enum logic [2:0] {
		br_beq  = 3'b000,
		br_bne  = 3'b001,
		br_blt  = 3'b100,
		br_bge  = 3'b101,
		br_bltu = 3'b110,
		br_bgeu = 3'b111
	} br_func_t;

	typedef enum logic [1:0] {opa_rs1, opa_pc, opa_zero} opa_sel_t;

	typedef enum logic {opb_rs2, opb_imm} opb_sel_t; // imm arrives sign-extended

endpackage

// ==== design/ex_types_pkg.sv ====
// execute-stage widths and unit select; tag 0 always means "no destination register"
package ex_types_pkg;

	////////////////////////////////////////////////////////////
	// widths
	////////////////////////////////////////////////////////////

	localparam int XLEN     = 32; // data word
	localparam int TAG_BITS = 6;  // physical register tag

	typedef logic [XLEN-1:0]     word_t;
	typedef logic [TAG_BITS-1:0] tag_t; // zero = no writeback

	////////////////////////////////////////////////////////////
	// unit steering
	////////////////////////////////////////////////////////////

	// which functional unit takes the issued instruction
	typedef enum logic [1:0] {
		unit_alu    = 2'd0,
		unit_mult   = 2'd1,
		unit_branch = 2'd2
	} exec_unit_t;

	////////////////////////////////////////////////////////////
	// default sizes for the top level
	////////////////////////////////////////////////////////////

	localparam int DEFAULT_MULT_STAGES = 4; // must divide XLEN
	localparam int DEFAULT_QUEUE_DEPTH = 8; // at least MULT_STAGES + 2

endpackage
